//--- project.f
source/calc_pkg.sv
source/op_if.sv
source/uart_receiver.sv
source/command_decoder.sv
source/alu_execute.sv
source/result_tx_ctrl.sv
source/uart_transmitter.sv
source/serial_calc_top.sv
tb/serial_calc_tb.sv

//--- source/alu_execute.sv
module alu_execute (
	input logic clock,
	input logic reset,
	op_if.execute op,
	output calc_pkg::word_t result,
	output logic result_valid
);
	import calc_pkg::*;

	word_t alu_value;

	// Operation select, everything truncated to 16 bits
	always_comb begin
		case (op.opcode)
			// Add and subtract wrap modulo 2^16
			OP_ADD: alu_value = op.operand_a + op.operand_b;
			OP_SUB: alu_value = op.operand_a - op.operand_b;
			OP_AND: alu_value = op.operand_a & op.operand_b;
			OP_OR: alu_value = op.operand_a | op.operand_b;
			OP_XOR: alu_value = op.operand_a ^ op.operand_b;
			// Only the low four bits of B count
			OP_SHL: alu_value = op.operand_a << op.operand_b[3:0];
			default: alu_value = '0;
		endcase
	end

	// Result strobe one cycle behind the operation strobe
	always_ff @(posedge clock) begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= op.valid;
	end

	// Result register, updated only for a valid operation
	always_ff @(posedge clock) begin
		if (op.valid)
			result <= alu_value;
	end

endmodule

//--- source/calc_pkg.sv
package calc_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// Data widths
	//////////////////////////////////////////////////////////////////////////////

	// One byte on the serial line
	typedef logic [7:0] byte_t;

	// Operand and result width
	typedef logic [15:0] word_t;

	// Command opcodes, carried in the first byte of a frame
	// Any other byte value is treated as illegal
	typedef enum logic [7:0] {
		OP_ADD = 8'h01,
		OP_SUB = 8'h02,
		OP_AND = 8'h03,
		OP_OR  = 8'h04,
		OP_XOR = 8'h05,
		// Shift amount taken from the low four bits of B
		OP_SHL = 8'h06
	} opcode_t;

	//////////////////////////////////////////////////////////////////////////////
	// Command frame layout
	//////////////////////////////////////////////////////////////////////////////

	localparam int FRAME_BYTES = 5;
	localparam int FRAME_COUNT_W = $clog2(FRAME_BYTES);

	// Byte positions inside a frame, operands little endian
	localparam int POS_OPCODE = 0;
	localparam int POS_A_LOW = 1;
	localparam int POS_A_HIGH = 2;
	localparam int POS_B_LOW = 3;
	localparam int POS_B_HIGH = 4;

endpackage

//--- source/command_decoder.sv
module command_decoder (
	input logic clock,
	input logic reset,
	input calc_pkg::byte_t rx_byte,
	input logic rx_strobe,
	op_if.decoder op
);
	import calc_pkg::*;

	logic [FRAME_COUNT_W-1:0] byte_count;
	logic last_byte;
	byte_t opcode_byte;
	word_t operand_a;
	word_t operand_b;

	// Only the listed opcodes are accepted
	function automatic logic is_legal(input byte_t code);
		case (code)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	assign last_byte = (byte_count == FRAME_COUNT_W'(FRAME_BYTES - 1));

	// Frame position counter, wraps after every frame, legal or not
	always_ff @(posedge clock) begin
		if (reset) begin
			byte_count <= '0;
			op.valid <= 1'b0;
		end else begin
			op.valid <= rx_strobe && last_byte && is_legal(opcode_byte);
			if (rx_strobe)
				byte_count <= last_byte ? '0 : byte_count + 1'b1;
		end
	end

	// Steer each byte to its field
	always_ff @(posedge clock) begin
		if (rx_strobe) begin
			case (byte_count)
				FRAME_COUNT_W'(POS_OPCODE): opcode_byte <= rx_byte;
				FRAME_COUNT_W'(POS_A_LOW): operand_a[7:0] <= rx_byte;
				FRAME_COUNT_W'(POS_A_HIGH): operand_a[15:8] <= rx_byte;
				FRAME_COUNT_W'(POS_B_LOW): operand_b[7:0] <= rx_byte;
				FRAME_COUNT_W'(POS_B_HIGH): operand_b[15:8] <= rx_byte;
				default: ;
			endcase
		end
	end

	// Fields stay stable until the next frame overwrites them
	assign op.opcode = opcode_t'(opcode_byte);
	assign op.operand_a = operand_a;
	assign op.operand_b = operand_b;

endmodule

//--- source/op_if.sv
interface op_if;
	import calc_pkg::*;

	// One-cycle strobe, fields below only meaningful while high
	logic valid;
	opcode_t opcode;
	word_t operand_a;
	word_t operand_b;

	// Frame decoder side
	modport decoder (
		output valid,
		output opcode,
		output operand_a,
		output operand_b
	);

	// Execute stage side
	modport execute (
		input valid,
		input opcode,
		input operand_a,
		input operand_b
	);

endinterface

//--- source/result_tx_ctrl.sv
module result_tx_ctrl #(
	parameter int INTER_BYTE_DELAY = 10000
) (
	input logic clock,
	input logic reset,
	input calc_pkg::word_t result,
	input logic result_valid,
	output calc_pkg::byte_t tx_data,
	output logic tx_start
);
	import calc_pkg::*;

	localparam int TIMER_W = $clog2(INTER_BYTE_DELAY + 1);

	typedef enum logic [2:0] {
		idle,
		send_low,
		delay_low,
		send_high,
		delay_high
	} ctrl_state_t;

	ctrl_state_t state;
	ctrl_state_t next_state;
	word_t result_reg;
	logic [TIMER_W-1:0] hold_timer;
	logic hold_done;

	// Delay states last INTER_BYTE_DELAY + 1 cycles, timer starts from zero
	assign hold_done = (hold_timer >= TIMER_W'(INTER_BYTE_DELAY));

	//////////////////////////////////////////////////////////////////////////////
	// Next state and strobe decode
	//////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		tx_start = 1'b0;
		tx_data = result_reg[7:0];
		case (state)
			idle: begin
				// Results arriving outside idle are dropped
				if (result_valid)
					next_state = send_low;
			end
			send_low: begin
				tx_start = 1'b1;
				next_state = delay_low;
			end
			delay_low: begin
				// Transmitter is idle again once the hold expires
				if (hold_done)
					next_state = send_high;
			end
			send_high: begin
				tx_data = result_reg[15:8];
				tx_start = 1'b1;
				next_state = delay_high;
			end
			delay_high: begin
				if (hold_done)
					next_state = idle;
			end
			default: next_state = idle;
		endcase
	end

	//////////////////////////////////////////////////////////////////////////////
	// State, capture and hold timer
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset)
			state <= idle;
		else
			state <= next_state;
	end

	// Result arrives already registered, capture directly in idle
	always_ff @(posedge clock) begin
		if (state == idle && result_valid)
			result_reg <= result;
	end

	// Timer runs only while holding after a byte start
	always_ff @(posedge clock) begin
		if (reset)
			hold_timer <= '0;
		else if (state == delay_low || state == delay_high)
			hold_timer <= hold_timer + 1'b1;
		else
			hold_timer <= '0;
	end

endmodule

//--- source/serial_calc_top.sv
module serial_calc_top #(
	parameter int CLKS_PER_BIT = 868,
	parameter int INTER_BYTE_DELAY = 10000
) (
	input logic clock,
	input logic reset,
	input logic rx,
	output logic tx
);
	import calc_pkg::*;

	//////////////////////////////////////////////////////////////////////////////
	// Command path
	//////////////////////////////////////////////////////////////////////////////

	byte_t rx_byte;
	logic rx_strobe;
	op_if op_bus ();

	uart_receiver #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) receiver (
		.clock(clock),
		.reset(reset),
		.rx(rx),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe)
	);

	command_decoder decoder (
		.clock(clock),
		.reset(reset),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe),
		.op(op_bus)
	);

	//////////////////////////////////////////////////////////////////////////////
	// Execute and reply path
	//////////////////////////////////////////////////////////////////////////////

	word_t result;
	logic result_valid;
	byte_t tx_data;
	logic tx_start;

	alu_execute execute (
		.clock(clock),
		.reset(reset),
		.op(op_bus),
		.result(result),
		.result_valid(result_valid)
	);

	// Two reply bytes, low first, paced by the inter-byte hold
	result_tx_ctrl #(
		.INTER_BYTE_DELAY(INTER_BYTE_DELAY)
	) reply_ctrl (
		.clock(clock),
		.reset(reset),
		.result(result),
		.result_valid(result_valid),
		.tx_data(tx_data),
		.tx_start(tx_start)
	);

	uart_transmitter #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) transmitter (
		.clock(clock),
		.reset(reset),
		.tx_data(tx_data),
		.tx_start(tx_start),
		.tx(tx)
	);

endmodule

//--- source/uart_receiver.sv
module uart_receiver #(
	parameter int CLKS_PER_BIT = 868
) (
	input logic clock,
	input logic reset,
	input logic rx,
	output calc_pkg::byte_t rx_byte,
	output logic rx_strobe
);
	localparam int COUNT_W = $clog2(CLKS_PER_BIT);
	localparam int HALF_BIT = (CLKS_PER_BIT - 1) / 2;

	typedef enum logic [1:0] {idle, start_bit, data_bits, stop_bit} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [COUNT_W-1:0] clk_count;
	logic [2:0] bit_index;
	logic bit_done;

	// Full bit period elapsed, lands on mid-bit once aligned by the start bit
	assign bit_done = (clk_count == COUNT_W'(CLKS_PER_BIT - 1));

	// Two-flop synchroniser, plus a delayed copy for edge detection
	always_ff @(posedge clock) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			clk_count <= '0;
			bit_index <= '0;
			rx_strobe <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			case (state)
				idle: begin
					clk_count <= '0;
					bit_index <= '0;
					// Falling edge marks a start bit
					if (rx_prev && !rx_sync)
						state <= start_bit;
				end
				start_bit: begin
					if (clk_count == COUNT_W'(HALF_BIT)) begin
						clk_count <= '0;
						// Line back high at mid-bit means a glitch
						state <= rx_sync ? idle : data_bits;
					end else begin
						clk_count <= clk_count + 1'b1;
					end
				end
				data_bits: begin
					if (bit_done) begin
						clk_count <= '0;
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7)
							state <= stop_bit;
					end else begin
						clk_count <= clk_count + 1'b1;
					end
				end
				stop_bit: begin
					// Stop level not checked, byte handed over at mid stop bit
					if (bit_done) begin
						clk_count <= '0;
						rx_strobe <= 1'b1;
						state <= idle;
					end else begin
						clk_count <= clk_count + 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Data sampled at mid-bit, LSB first, so shift in from the top
	always_ff @(posedge clock) begin
		if (state == data_bits && bit_done)
			rx_byte <= {rx_sync, rx_byte[7:1]};
	end

endmodule

//--- source/uart_transmitter.sv
module uart_transmitter #(
	parameter int CLKS_PER_BIT = 868
) (
	input logic clock,
	input logic reset,
	input calc_pkg::byte_t tx_data,
	input logic tx_start,
	output logic tx
);
	import calc_pkg::*;

	localparam int COUNT_W = $clog2(CLKS_PER_BIT);

	typedef enum logic [1:0] {idle, start_bit, data_bits, stop_bit} tx_state_t;

	tx_state_t state;
	byte_t data_reg;
	logic [COUNT_W-1:0] clk_count;
	logic [2:0] bit_index;
	logic bit_done;

	assign bit_done = (clk_count == COUNT_W'(CLKS_PER_BIT - 1));

	// Line level registered, start bit appears the cycle after tx_start
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			tx <= 1'b1;
			clk_count <= '0;
			bit_index <= '0;
		end else begin
			// Bit timer free runs outside idle, cleared at each bit boundary
			if (state == idle || bit_done)
				clk_count <= '0;
			else
				clk_count <= clk_count + 1'b1;
			case (state)
				idle: begin
					bit_index <= '0;
					// Start pulses while busy are ignored
					if (tx_start) begin
						tx <= 1'b0;
						state <= start_bit;
					end
				end
				start_bit: begin
					if (bit_done) begin
						tx <= data_reg[0];
						state <= data_bits;
					end
				end
				data_bits: begin
					if (bit_done) begin
						if (bit_index == 3'd7) begin
							tx <= 1'b1;
							state <= stop_bit;
						end else begin
							tx <= data_reg[bit_index + 3'd1];
							bit_index <= bit_index + 1'b1;
						end
					end
				end
				stop_bit: begin
					if (bit_done)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// Byte held for the whole frame
	always_ff @(posedge clock) begin
		if (state == idle && tx_start)
			data_reg <= tx_data;
	end

endmodule

//--- tb/serial_calc_tb.sv
module serial_calc_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import calc_pkg::*;

	localparam int CLKS_PER_BIT = 8;
	localparam int INTER_BYTE_DELAY = 100;
	// One command frame on the line, ten bits per byte
	localparam int FRAME_CYCLES = FRAME_BYTES * 10 * CLKS_PER_BIT;
	localparam int REPLY_TIMEOUT = FRAME_CYCLES + 2 * INTER_BYTE_DELAY + 20 * CLKS_PER_BIT;
	// Long enough to cover both reply bytes had any been sent
	localparam int SILENCE_CYCLES = FRAME_CYCLES + 3 * INTER_BYTE_DELAY + 20 * CLKS_PER_BIT;

	logic clock;
	logic reset;
	logic rx;
	logic tx;
	integer seed;
	int test_count;
	int fail_count;

	serial_calc_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.INTER_BYTE_DELAY(INTER_BYTE_DELAY)
	) DUT (
		.clock(clock),
		.reset(reset),
		.rx(rx),
		.tx(tx)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////////////
	// Expected results, modular arithmetic on plain integers
	//////////////////////////////////////////////////////////////////////////////

	function automatic word_t calc_expected(input opcode_t op, input word_t a, input word_t b);
		longint t;
		t = 0;
		case (op)
			OP_ADD: t = (longint'(a) + longint'(b)) % 65536;
			OP_SUB: t = (longint'(a) - longint'(b) + 65536) % 65536;
			OP_AND: t = longint'(a & b);
			OP_OR: t = longint'(a | b);
			OP_XOR: t = longint'(a ^ b);
			// Shift amount is B modulo 16
			OP_SHL: t = (longint'(a) * (longint'(1) << (b % 16))) % 65536;
			default: t = 0;
		endcase
		return word_t'(t);
	endfunction

	//////////////////////////////////////////////////////////////////////////////
	// Serial driver
	//////////////////////////////////////////////////////////////////////////////

	// One bit on rx, held for a full bit period
	task automatic drive_bit(input logic level);
		@(posedge clock);
		rx <= level;
		repeat (CLKS_PER_BIT - 1) @(posedge clock);
	endtask

	task automatic send_byte(input byte_t value);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(value[i]);
		drive_bit(1'b1);
	endtask

	// Opcode, then A and B, each low byte first
	task automatic send_frame(input byte_t code, input word_t a, input word_t b);
		send_byte(code);
		send_byte(a[7:0]);
		send_byte(a[15:8]);
		send_byte(b[7:0]);
		send_byte(b[15:8]);
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// Serial monitor and compare tasks
	//////////////////////////////////////////////////////////////////////////////

	// Sampled on falling clock edges, away from the DUT's own updates
	task automatic receive_byte(input string name, output byte_t value, output bit ok);
		int waited;
		int i;
		bit seen;
		value = '0;
		ok = 1'b0;
		seen = 1'b0;
		waited = 0;
		while (!seen && waited < REPLY_TIMEOUT) begin
			@(negedge clock);
			if (tx === 1'b0)
				seen = 1'b1;
			else
				waited++;
		end
		if (!seen) begin
			$display("[FAIL] %s: no start bit on tx within %0d cycles", name, REPLY_TIMEOUT);
			return;
		end
		// Move to the middle of the start bit
		repeat (CLKS_PER_BIT / 2) @(negedge clock);
		if (tx !== 1'b0) begin
			$display("[FAIL] %s: start bit on tx ended before mid-bit", name);
			return;
		end
		for (i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clock);
			value[i] = tx;
		end
		repeat (CLKS_PER_BIT) @(negedge clock);
		if (tx !== 1'b1) begin
			$display("[FAIL] %s: stop bit on tx is low", name);
			return;
		end
		ok = 1'b1;
	endtask

	task automatic check_word(input string name, input word_t expected,
			input byte_t low_byte, input byte_t high_byte);
		word_t actual;
		actual = {high_byte, low_byte};
		test_count++;
		if (actual !== expected) begin
			fail_count++;
			$display("[ERROR] %s: expected %h actual %h", name, expected, actual);
		end else begin
			$display("[PASS] %s: result %h", name, actual);
		end
	endtask

	// Any start bit inside the window is a reply that should not exist
	task automatic check_silence(input string name);
		int waited;
		bit seen;
		seen = 1'b0;
		waited = 0;
		while (!seen && waited < SILENCE_CYCLES) begin
			@(negedge clock);
			if (tx === 1'b0)
				seen = 1'b1;
			waited++;
		end
		test_count++;
		if (seen) begin
			fail_count++;
			$display("[FAIL] %s: a reply started on tx although none was expected", name);
		end else begin
			$display("[PASS] %s: no reply", name);
		end
	endtask

	// Frame out and reply in run side by side, the reply may start right after the stop bit
	task automatic run_test(input string name, input opcode_t op, input word_t a, input word_t b);
		byte_t low_byte;
		byte_t high_byte;
		bit low_ok;
		bit high_ok;
		high_ok = 1'b0;
		fork
			send_frame(byte_t'(op), a, b);
			begin
				receive_byte(name, low_byte, low_ok);
				if (low_ok)
					receive_byte(name, high_byte, high_ok);
			end
		join
		if (low_ok && high_ok) begin
			check_word(name, calc_expected(op, a, b), low_byte, high_byte);
		end else begin
			test_count++;
			fail_count++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////////////

	initial begin
		opcode_t op;
		word_t a;
		word_t b;
		int n;
		int idx;
		reset = 1'b1;
		rx = 1'b1;
		seed = 64031;
		test_count = 0;
		fail_count = 0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		repeat (4) @(posedge clock);

		// Every opcode with fixed operands
		run_test("add", OP_ADD, 16'h1234, 16'h0F0F);
		run_test("sub", OP_SUB, 16'h9000, 16'h1234);
		run_test("and", OP_AND, 16'hF0F0, 16'h3C3C);
		run_test("or", OP_OR, 16'h0A50, 16'h4005);
		run_test("xor", OP_XOR, 16'hFFFF, 16'h5A5A);
		run_test("shl", OP_SHL, 16'h0123, 16'h0004);

		// Random legal frames
		for (n = 0; n < 40; n++) begin
			idx = $unsigned($random(seed)) % 6;
			op = opcode_t'(idx + 1);
			a = word_t'($random(seed));
			b = word_t'($random(seed));
			run_test($sformatf("random %0d", n), op, a, b);
		end

		// Wrap and shift boundaries
		run_test("add wrap", OP_ADD, 16'hFFFF, 16'h0001);
		run_test("sub wrap", OP_SUB, 16'h0000, 16'h0001);
		run_test("shl by 15", OP_SHL, 16'h0003, 16'h000F);
		run_test("shl by 0x13", OP_SHL, 16'h8001, 16'h0013);
		run_test("shl by 0x10", OP_SHL, 16'hABCD, 16'h0010);

		// Illegal opcodes are dropped, the next frame must still decode
		fork
			send_frame(8'h07, 16'h1111, 16'h2222);
			check_silence("illegal opcode 0x07");
		join
		fork
			send_frame(8'h00, 16'h3333, 16'h4444);
			check_silence("illegal opcode 0x00");
		join
		run_test("legal after illegal", OP_SUB, 16'h5000, 16'h1234);

		// Back to back, high and low bytes all distinct
		run_test("order 0x1234", OP_ADD, 16'h1200, 16'h0034);
		run_test("order 0xaa55", OP_XOR, 16'hA55A, 16'h0F0F);
		run_test("order 0x0ff0", OP_OR, 16'h00F0, 16'h0F00);

		$display("tests run %0d, failed %0d", test_count, fail_count);
		if (fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
